// ==== design/spikeConf_params.svh ====
`ifndef SPIKECONF_PARAMS_SVH
`define SPIKECONF_PARAMS_SVH

// size of the configuration register bank
`define NREG 8

// host input queue depth, equal to the host's starting credits
`define HOST_CREDITS 4

// spike output credits held by the generator walk
`define SPIKE_CREDITS 2

// number of spike generators in program memory
`define NGENS 8

// clocks per time unit, short value for simulation
// the chip build runs with 10000 here
`define TIME_UNIT_DEFAULT 20

// time units per heartbeat
`define HB_DEFAULT 10

`endif

// ==== design/ConfPkg.sv ====
package ConfPkg;

  // one configuration register, also one host word
  typedef logic [15:0] confWord;

  // register index into the bank
  typedef logic [2:0] confAddr;

  // opcode in bits 15:14 of a header word
  // reads are header only, writes and chunks carry one data word
  typedef enum logic [1:0] {
    REG_WRITE  = 2'd0,
    PROG_CHUNK = 2'd1,
    REG_READ   = 2'd2
  } hostOp;

  // host word parser
  typedef enum logic {
    HDR,
    DATA
  } parseState;

endpackage

// ==== design/SpikePkg.sv ====
package SpikePkg;

  typedef logic [2:0] genIdx;
  typedef logic [15:0] genPeriod;
  typedef logic [10:0] spikeTag;

  // {genIdx, genPeriod, spikeTag}, index in the top bits
  typedef logic [29:0] progEntry;

  // generator walk
  typedef enum logic [1:0] {
    IDLE,
    READ,
    UPDATE
  } walkState;

endpackage

// ==== design/ConfBus.sv ====
`timescale 1ns/1ns

// program entry handoff, transfer when valid and ack are both high
interface ProgEntryChan;
  logic valid;
  SpikePkg::progEntry entry;
  logic ack;

  modport src (output valid, output entry, input ack);
  modport dst (input valid, input entry, output ack);
endinterface

// program memory access port
// req held until gnt, rdata valid the cycle after gnt
interface ProgMemPort;
  logic req;
  logic we;
  SpikePkg::genIdx addr;
  SpikePkg::progEntry wdata;
  logic gnt;
  SpikePkg::progEntry rdata;

  modport client (output req, output we, output addr, output wdata, input gnt, input rdata);
  modport mem (input req, input we, input addr, input wdata, output gnt, output rdata);
endinterface

// ==== design/HostConfPort.sv ====
`timescale 1ns/1ns
`include "spikeConf_params.svh"

module HostConfPort (
  input  logic clk,
  input  logic reset,
  input  logic hostValid,
  input  ConfPkg::confWord hostWord,
  output logic hostCredit,
  output logic rdValid,
  output ConfPkg::confWord rdData,
  output logic chunkValid,
  output ConfPkg::confWord chunk,
  input  logic progBusy,
  input  ConfPkg::confWord [`NREG-1:0] resetValues,
  output ConfPkg::confWord [`NREG-1:0] regValues
);

  // queue depth is a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(`HOST_CREDITS);

  ConfPkg::confWord queue [`HOST_CREDITS];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [PTR_W:0] fill;
  ConfPkg::confWord head;
  ConfPkg::hostOp headOp;
  ConfPkg::parseState state;
  ConfPkg::hostOp curOp;
  ConfPkg::confAddr curAddr;
  logic rdPending;
  logic chunkStall;
  logic pop;

  assign head = queue[rdPtr];
  assign headOp = ConfPkg::hostOp'(head[15:14]);

  // a chunk waits while the deserializer still holds an entry or one is in flight
  assign chunkStall = (curOp == ConfPkg::PROG_CHUNK) && (progBusy || chunkValid);
  assign pop = (fill != '0) && !((state == ConfPkg::DATA) && chunkStall);

  ////////////////////////////////////////////////////////////
  // input queue, one credit back per popped word

  always_ff @(posedge clk) begin
    if (reset) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill <= '0;
      hostCredit <= 1'b0;
    end else begin
      if (hostValid) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      fill <= fill + {{PTR_W{1'b0}}, hostValid} - {{PTR_W{1'b0}}, pop};
      hostCredit <= pop;
    end
  end

  ////////////////////////////////////////////////////////////
  // parser and register bank

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= ConfPkg::HDR;
      curOp <= ConfPkg::REG_WRITE;
      curAddr <= '0;
      rdPending <= 1'b0;
      rdValid <= 1'b0;
      chunkValid <= 1'b0;
      regValues <= resetValues;
    end else begin
      rdPending <= 1'b0;
      chunkValid <= 1'b0;
      rdValid <= rdPending;
      if (pop) begin
        case (state)
          ConfPkg::HDR: begin
            curOp <= headOp;
            curAddr <= head[2:0];
            rdPending <= (headOp == ConfPkg::REG_READ);
            if (headOp == ConfPkg::REG_WRITE || headOp == ConfPkg::PROG_CHUNK) begin
              state <= ConfPkg::DATA;
            end
          end
          ConfPkg::DATA: begin
            if (curOp == ConfPkg::REG_WRITE) begin
              regValues[curAddr] <= head;
            end else begin
              chunkValid <= 1'b1;
            end
            state <= ConfPkg::HDR;
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk) begin
    if (hostValid) begin
      queue[wrPtr] <= hostWord;
    end
    if (pop && state == ConfPkg::DATA) begin
      chunk <= head;
    end
    if (rdPending) begin
      rdData <= regValues[curAddr];
    end
  end

  // host sends only while it holds a credit
  assert property (@(posedge clk) disable iff (reset)
    hostValid |-> fill != `HOST_CREDITS);

endmodule

// ==== design/ConfMapper.sv ====
`timescale 1ns/1ns
`include "spikeConf_params.svh"

module ConfMapper (
  input  ConfPkg::confWord [`NREG-1:0] regValues,
  output ConfPkg::confWord [`NREG-1:0] resetValues,
  output ConfPkg::confWord gensEn,
  output ConfPkg::confWord unitLen,
  output ConfPkg::confWord hbEvery,
  output logic timeReset
);

  ////////////////////////////////////////////////////////////
  // register map

  localparam int GENS_EN_IDX    = 0;
  localparam int UNIT_LEN_IDX   = 1;
  localparam int HB_EVERY_IDX   = 2;
  localparam int TIME_RESET_IDX = 3;
  localparam int FIRST_FREE_IDX = TIME_RESET_IDX + 1;

  // field slices
  assign gensEn    = regValues[GENS_EN_IDX];
  assign unitLen   = regValues[UNIT_LEN_IDX];
  assign hbEvery   = regValues[HB_EVERY_IDX];
  assign timeReset = regValues[TIME_RESET_IDX][0];

  ////////////////////////////////////////////////////////////
  // reset values

  // all generators off
  assign resetValues[GENS_EN_IDX]    = '0;
  assign resetValues[UNIT_LEN_IDX]   = ConfPkg::confWord'(`TIME_UNIT_DEFAULT);
  assign resetValues[HB_EVERY_IDX]   = ConfPkg::confWord'(`HB_DEFAULT);
  assign resetValues[TIME_RESET_IDX] = '0;

  // spare registers
  assign resetValues[`NREG-1:FIRST_FREE_IDX] = '0;

endmodule

// ==== design/Deserializer.sv ====
`timescale 1ns/1ns

module Deserializer (
  input logic clk,
  input logic reset,
  input logic chunkValid,
  input ConfPkg::confWord chunk,
  ProgEntryChan.src entryOut
);

  // bits of the high chunk that land in the entry
  localparam int HIGH_W = $bits(SpikePkg::progEntry) - $bits(ConfPkg::confWord);

  ConfPkg::confWord lowChunk;
  logic haveLow;

  always_ff @(posedge clk) begin
    if (reset) begin
      haveLow <= 1'b0;
      entryOut.valid <= 1'b0;
    end else begin
      if (entryOut.valid && entryOut.ack) begin
        entryOut.valid <= 1'b0;
      end
      if (chunkValid) begin
        haveLow <= !haveLow;
        if (haveLow) begin
          entryOut.valid <= 1'b1;
        end
      end
    end
  end

  // low chunk first, then high chunk completes the entry
  always_ff @(posedge clk) begin
    if (chunkValid && !haveLow) begin
      lowChunk <= chunk;
    end
    if (chunkValid && haveLow) begin
      entryOut.entry <= {chunk[HIGH_W-1:0], lowChunk};
    end
  end

  // parser must pause while an entry waits for the arbiter
  assert property (@(posedge clk) disable iff (reset)
    chunkValid |-> !entryOut.valid);

endmodule

// ==== design/ProgMemArbiter.sv ====
`timescale 1ns/1ns
`include "spikeConf_params.svh"

module ProgMemArbiter (
  input logic clk,
  input logic reset,
  ProgEntryChan.dst writer,
  ProgMemPort.mem reader
);

  localparam int TAG_W  = $bits(SpikePkg::spikeTag);
  localparam int PER_W  = $bits(SpikePkg::genPeriod);
  localparam int SLOT_W = TAG_W + PER_W;

  // period and tag per generator
  logic [SLOT_W-1:0] slots [`NGENS];
  logic [SLOT_W-1:0] rdSlot;
  SpikePkg::genIdx rdIdx;
  SpikePkg::genIdx wrIdx;
  logic lastWriter;
  logic grantW;
  logic grantR;

  assign wrIdx = writer.entry[SLOT_W +: $bits(SpikePkg::genIdx)];

  // round robin where the port not served last wins a tie
  assign grantW = writer.valid && (!reader.req || !lastWriter);
  assign grantR = reader.req && !grantW;
  assign writer.ack = grantW;
  assign reader.gnt = grantR;
  assign reader.rdata = {rdIdx, rdSlot};

  always_ff @(posedge clk) begin
    if (reset) begin
      lastWriter <= 1'b0;
    end else if (grantW) begin
      lastWriter <= 1'b1;
    end else if (grantR) begin
      lastWriter <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (grantW) begin
      slots[wrIdx] <= writer.entry[SLOT_W-1:0];
    end else if (grantR && reader.we) begin
      slots[reader.addr] <= reader.wdata[SLOT_W-1:0];
    end
    if (grantR) begin
      rdIdx <= reader.addr;
      rdSlot <= slots[reader.addr];
    end
  end

  // a writer turned away gets the very next grant
  assert property (@(posedge clk) disable iff (reset)
    writer.valid && !writer.ack |=> writer.ack);

endmodule

// ==== design/SpikeGen.sv ====
`timescale 1ns/1ns
`include "spikeConf_params.svh"

module SpikeGen (
  input  logic clk,
  input  logic reset,
  input  logic tick,
  input  ConfPkg::confWord gensEn,
  ProgMemPort.client mem,
  output logic spikeValid,
  output SpikePkg::spikeTag spikeTag,
  input  logic spikeCredit
);

  localparam int TAG_W  = $bits(SpikePkg::spikeTag);
  localparam int PER_W  = $bits(SpikePkg::genPeriod);
  localparam int CRED_W = $clog2(`SPIKE_CREDITS + 1);

  SpikePkg::walkState state;
  SpikePkg::genIdx idx;
  SpikePkg::genPeriod counts [`NGENS];
  SpikePkg::genPeriod period;
  SpikePkg::spikeTag tag;
  logic [3:0] pending;
  logic [CRED_W-1:0] credits;
  logic enabled;
  logic needSpike;
  logic lastGen;
  logic start;
  logic emit;

  assign enabled   = gensEn[idx];
  assign needSpike = (counts[idx] == '0);
  assign lastGen   = (idx == SpikePkg::genIdx'(`NGENS - 1));
  assign start     = (state == SpikePkg::IDLE) && (pending != '0);
  assign emit      = (state == SpikePkg::UPDATE) && needSpike;

  // a generator due to fire is not read until a credit is there
  assign mem.req   = (state == SpikePkg::READ) && enabled && (!needSpike || credits != '0);
  assign mem.we    = 1'b0;
  assign mem.wdata = '0;
  assign mem.addr  = idx;
  assign period    = mem.rdata[TAG_W +: PER_W];
  assign tag       = mem.rdata[TAG_W-1:0];

  ////////////////////////////////////////////////////////////
  // pending ticks and output credits

  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= '0;
      credits <= CRED_W'(`SPIKE_CREDITS);
    end else begin
      if (tick && !start && pending != 4'd15) begin
        pending <= pending + 1'b1;
      end else if (!tick && start) begin
        pending <= pending - 1'b1;
      end
      credits <= credits + {{(CRED_W-1){1'b0}}, spikeCredit} - {{(CRED_W-1){1'b0}}, emit};
    end
  end

  ////////////////////////////////////////////////////////////
  // generator walk

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= SpikePkg::IDLE;
      idx <= '0;
      spikeValid <= 1'b0;
      for (int i = 0; i < `NGENS; i++) begin
        counts[i] <= '0;
      end
    end else begin
      spikeValid <= emit;
      case (state)
        SpikePkg::IDLE: begin
          if (start) begin
            idx <= '0;
            state <= SpikePkg::READ;
          end
        end
        SpikePkg::READ: begin
          if (!enabled) begin
            if (lastGen) begin
              state <= SpikePkg::IDLE;
            end else begin
              idx <= idx + 1'b1;
            end
          end else if (mem.gnt) begin
            state <= SpikePkg::UPDATE;
          end
        end
        SpikePkg::UPDATE: begin
          // fire and reload, or count down
          if (needSpike) begin
            counts[idx] <= period - 1'b1;
          end else begin
            counts[idx] <= counts[idx] - 1'b1;
          end
          if (lastGen) begin
            state <= SpikePkg::IDLE;
          end else begin
            idx <= idx + 1'b1;
            state <= SpikePkg::READ;
          end
        end
        default: state <= SpikePkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (emit) begin
      spikeTag <= tag;
    end
  end

  // receiver returns no more credits than it was given
  assert property (@(posedge clk) disable iff (reset)
    credits <= CRED_W'(`SPIKE_CREDITS));

  assert property (@(posedge clk) disable iff (reset)
    spikeValid |-> $past(credits) != '0);

endmodule

// ==== design/TimeMgr.sv ====
`timescale 1ns/1ns

module TimeMgr (
  input  logic clk,
  input  logic reset,
  input  ConfPkg::confWord unitLen,
  input  ConfPkg::confWord hbEvery,
  input  logic timeReset,
  output logic tick,
  output logic hbPulse
);

  ConfPkg::confWord cycleCnt;
  ConfPkg::confWord unitCnt;
  logic timeResetQ;
  logic unitDone;

  // compare with >= so a shrinking unitLen cannot strand the counter
  assign unitDone = (cycleCnt >= unitLen - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      cycleCnt <= '0;
      unitCnt <= '0;
      timeResetQ <= 1'b0;
      tick <= 1'b0;
      hbPulse <= 1'b0;
    end else begin
      timeResetQ <= timeReset;
      tick <= 1'b0;
      hbPulse <= 1'b0;
      if (timeReset && !timeResetQ) begin
        cycleCnt <= '0;
        unitCnt <= '0;
      end else if (unitDone) begin
        cycleCnt <= '0;
        tick <= 1'b1;
        // heartbeat rides on every hbEvery-th tick
        if (unitCnt >= hbEvery - 1'b1) begin
          unitCnt <= '0;
          hbPulse <= 1'b1;
        end else begin
          unitCnt <= unitCnt + 1'b1;
        end
      end else begin
        cycleCnt <= cycleCnt + 1'b1;
      end
    end
  end

endmodule

// ==== design/SpikeCore.sv ====
`timescale 1ns/1ns
`include "spikeConf_params.svh"

module SpikeCore (
  input  logic clk,
  input  logic reset,
  input  logic hostValid,
  input  ConfPkg::confWord hostWord,
  output logic hostCredit,
  output logic rdValid,
  output ConfPkg::confWord rdData,
  output logic spikeValid,
  output SpikePkg::spikeTag spikeTag,
  input  logic spikeCredit,
  output logic hbPulse,
  output logic tick
);

  ConfPkg::confWord [`NREG-1:0] regValues;
  ConfPkg::confWord [`NREG-1:0] resetValues;
  ConfPkg::confWord chunk;
  ConfPkg::confWord gensEn;
  ConfPkg::confWord unitLen;
  ConfPkg::confWord hbEvery;
  logic chunkValid;
  logic timeReset;

  ProgEntryChan entryChan ();
  ProgMemPort memPort ();

  ////////////////////////////////////////////////////////////
  // configuration path

  HostConfPort HostConfPort_i (
    .clk(clk),
    .reset(reset),
    .hostValid(hostValid),
    .hostWord(hostWord),
    .hostCredit(hostCredit),
    .rdValid(rdValid),
    .rdData(rdData),
    .chunkValid(chunkValid),
    .chunk(chunk),
    .progBusy(entryChan.valid),
    .resetValues(resetValues),
    .regValues(regValues)
  );

  ConfMapper ConfMapper_i (
    .regValues(regValues),
    .resetValues(resetValues),
    .gensEn(gensEn),
    .unitLen(unitLen),
    .hbEvery(hbEvery),
    .timeReset(timeReset)
  );

  ////////////////////////////////////////////////////////////
  // program memory and spike path

  Deserializer Deserializer_i (
    .clk(clk),
    .reset(reset),
    .chunkValid(chunkValid),
    .chunk(chunk),
    .entryOut(entryChan.src)
  );

  ProgMemArbiter ProgMemArbiter_i (
    .clk(clk),
    .reset(reset),
    .writer(entryChan.dst),
    .reader(memPort.mem)
  );

  SpikeGen SpikeGen_i (
    .clk(clk),
    .reset(reset),
    .tick(tick),
    .gensEn(gensEn),
    .mem(memPort.client),
    .spikeValid(spikeValid),
    .spikeTag(spikeTag),
    .spikeCredit(spikeCredit)
  );

  TimeMgr TimeMgr_i (
    .clk(clk),
    .reset(reset),
    .unitLen(unitLen),
    .hbEvery(hbEvery),
    .timeReset(timeReset),
    .tick(tick),
    .hbPulse(hbPulse)
  );

endmodule

// ==== testbench/SpikeCoreTb.sv ====
`timescale 1ns/1ns
`include "spikeConf_params.svh"

module SpikeCoreTb;

  localparam int SEED = 29047;
  localparam int WAIT_LIMIT = 200;
  localparam int HB_LIMIT = 2000;
  localparam int UNIT_LEN = 60;
  localparam int HB_EVERY = 12;
  localparam int HB_GAP = UNIT_LEN * HB_EVERY;
  // edges from the data word entering the empty queue to the counter clear
  localparam int RESET_LATENCY = 2;
  localparam int NWRITES = 5;
  localparam int NPROG = 5;

  logic clk;
  logic reset;
  logic hostValid;
  ConfPkg::confWord hostWord;
  logic hostCredit;
  logic rdValid;
  ConfPkg::confWord rdData;
  logic spikeValid;
  SpikePkg::spikeTag spikeTag;
  logic spikeCredit;
  logic hbPulse;
  logic tick;

  int hostCreds;
  int owed;
  int valueErrors;
  int otherErrors;
  int spikeTotal;
  int tagCount [2048];
  logic holdCredits;
  logic [31:0] jitter;

  // expected register contents right after reset
  ConfPkg::confWord rstExp [`NREG] = '{16'd0, 16'(`TIME_UNIT_DEFAULT), 16'(`HB_DEFAULT),
                                       16'd0, 16'd0, 16'd0, 16'd0, 16'd0};

  // register writes: address, data, readback
  ConfPkg::confAddr wrAddr [NWRITES] = '{3'd5, 3'd7, 3'd1, 3'd2, 3'd0};
  ConfPkg::confWord wrData [NWRITES] = '{16'hA5C3, 16'h1234, 16'(UNIT_LEN), 16'(HB_EVERY),
                                         16'h0056};
  ConfPkg::confWord wrExp [NWRITES] = '{16'hA5C3, 16'h1234, 16'(UNIT_LEN), 16'(HB_EVERY),
                                        16'h0056};

  // program entries and spikes per heartbeat, gen 5 stays disabled
  SpikePkg::genIdx pgGen [NPROG] = '{3'd1, 3'd2, 3'd4, 3'd6, 3'd5};
  SpikePkg::genPeriod pgPeriod [NPROG] = '{16'd1, 16'd3, 16'd4, 16'd6, 16'd2};
  SpikePkg::spikeTag pgTag [NPROG] = '{11'h101, 11'h232, 11'h044, 11'h6A6, 11'h555};
  int pgPerHb [NPROG] = '{12, 4, 3, 2, 0};

  SpikeCore SpikeCore_i (
    .clk(clk),
    .reset(reset),
    .hostValid(hostValid),
    .hostWord(hostWord),
    .hostCredit(hostCredit),
    .rdValid(rdValid),
    .rdData(rdData),
    .spikeValid(spikeValid),
    .spikeTag(spikeTag),
    .spikeCredit(spikeCredit),
    .hbPulse(hbPulse),
    .tick(tick)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #20 clk = ~clk;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic ConfPkg::confWord header(input ConfPkg::hostOp op,
                                              input ConfPkg::confAddr addr);
    return {op, 11'd0, addr};
  endfunction

  task automatic reportMismatch(input string name, input int got, input int exp);
    valueErrors++;
    $display("ERR %0t ns %s got %0d expected %0d", $time, name, got, exp);
  endtask

  ////////////////////////////////////////////////////////////
  // monitors and the spike credit model

  always @(negedge clk) begin
    if (hostCredit) begin
      hostCreds++;
    end
    if (hostCreds > `HOST_CREDITS) begin
      otherErrors++;
      $display("host got back more credits than it owns at %0t ns", $time);
    end
    if (spikeValid) begin
      tagCount[spikeTag]++;
      spikeTotal++;
      owed++;
    end
    if (owed > `SPIKE_CREDITS) begin
      otherErrors++;
      $display("spike sent without a credit at %0t ns", $time);
    end
  end

  // return credits with random gaps, none while held
  initial begin
    jitter = 32'(SEED);
    forever begin
      @(posedge clk);
      #2;
      jitter = xorshift(jitter);
      if (owed > 0 && !holdCredits && jitter[0]) begin
        spikeCredit = 1'b1;
        owed--;
      end else begin
        spikeCredit = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // host side

  task automatic sendWord(input ConfPkg::confWord w);
    int n;
    n = 0;
    while (hostCreds == 0 && n < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (hostCreds == 0) begin
      otherErrors++;
      $display("host credit never came back at %0t ns", $time);
    end
    hostValid = 1'b1;
    hostWord = w;
    hostCreds--;
    if (hostCreds < 0) begin
      otherErrors++;
      $display("host credit count went negative at %0t ns", $time);
    end
    @(posedge clk);
    #2;
    hostValid = 1'b0;
  endtask

  task automatic writeReg(input ConfPkg::confAddr addr, input ConfPkg::confWord data);
    sendWord(header(ConfPkg::REG_WRITE, addr));
    sendWord(data);
  endtask

  task automatic readCheck(input ConfPkg::confAddr addr, input ConfPkg::confWord exp);
    int n;
    n = 0;
    sendWord(header(ConfPkg::REG_READ, addr));
    while (!rdValid && n < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!rdValid) begin
      otherErrors++;
      $display("no read data for register %0d at %0t ns", addr, $time);
    end else if (rdData !== exp) begin
      reportMismatch($sformatf("rdData reg %0d", addr), rdData, exp);
    end
    // step past the read pulse
    @(posedge clk);
    #2;
  endtask

  // low chunk first
  task automatic sendEntry(input SpikePkg::genIdx gen, input SpikePkg::genPeriod per,
                           input SpikePkg::spikeTag tag);
    SpikePkg::progEntry entry;
    entry = {gen, per, tag};
    sendWord(header(ConfPkg::PROG_CHUNK, 3'd0));
    sendWord(entry[15:0]);
    sendWord(header(ConfPkg::PROG_CHUNK, 3'd0));
    sendWord({2'b00, entry[29:16]});
  endtask

  ////////////////////////////////////////////////////////////
  // time and spike checks

  task automatic waitHb(output int cycles);
    cycles = 0;
    do begin
      @(posedge clk);
      #2;
      cycles++;
    end while (!hbPulse && cycles < HB_LIMIT);
    if (!hbPulse) begin
      otherErrors++;
      $display("no heartbeat within %0d cycles at %0t ns", HB_LIMIT, $time);
    end
  endtask

  task automatic waitTick(output logic sawHb);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      #2;
      n++;
    end while (!tick && n < WAIT_LIMIT);
    sawHb = hbPulse;
    if (!tick) begin
      otherErrors++;
      $display("no tick within %0d cycles at %0t ns", WAIT_LIMIT, $time);
    end
  endtask

  task automatic clearCounts();
    for (int i = 0; i < 2048; i++) begin
      tagCount[i] = 0;
    end
    spikeTotal = 0;
  endtask

  task automatic checkCounts(input int beats);
    int expTotal;
    expTotal = 0;
    for (int i = 0; i < NPROG; i++) begin
      expTotal += pgPerHb[i] * beats;
      if (tagCount[pgTag[i]] != pgPerHb[i] * beats) begin
        reportMismatch($sformatf("spikes of tag %0h", pgTag[i]), tagCount[pgTag[i]],
                       pgPerHb[i] * beats);
      end
    end
    // catches tags that are in no table entry
    if (spikeTotal != expTotal) begin
      reportMismatch("spike total", spikeTotal, expTotal);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    int gap;
    int holdTicks;
    int beats;
    int n;
    logic sawHb;
    reset = 1'b1;
    hostValid = 1'b0;
    hostWord = '0;
    spikeCredit = 1'b0;
    holdCredits = 1'b0;
    hostCreds = `HOST_CREDITS;
    owed = 0;
    valueErrors = 0;
    otherErrors = 0;
    clearCounts();
    holdTicks = int'(xorshift(xorshift(32'(SEED))) % 32'd14) + 1;
    repeat (2) @(posedge clk);
    #2;
    reset = 1'b0;

    if ({hostCredit, rdValid, spikeValid, tick, hbPulse} !== 5'b0) begin
      reportMismatch("outputs after reset", {hostCredit, rdValid, spikeValid, tick, hbPulse}, 0);
    end

    for (int a = 0; a < `NREG; a++) begin
      readCheck(ConfPkg::confAddr'(a), rstExp[a]);
    end

    for (int i = 0; i < NPROG; i++) begin
      sendEntry(pgGen[i], pgPeriod[i], pgTag[i]);
    end

    for (int i = 0; i < NWRITES; i++) begin
      writeReg(wrAddr[i], wrData[i]);
      readCheck(wrAddr[i], wrExp[i]);
    end

    // first heartbeat may still follow the old unit count
    waitHb(gap);
    waitHb(gap);
    if (gap != HB_GAP) begin
      reportMismatch("heartbeat gap", gap, HB_GAP);
    end
    clearCounts();
    waitHb(gap);
    if (gap != HB_GAP) begin
      reportMismatch("heartbeat gap", gap, HB_GAP);
    end
    checkCounts(1);

    // withhold spike credits, backlog drains within three heartbeats
    clearCounts();
    beats = 0;
    holdCredits = 1'b1;
    for (int t = 0; t < holdTicks; t++) begin
      waitTick(sawHb);
      if (sawHb) begin
        beats++;
      end
    end
    holdCredits = 1'b0;
    while (beats < 3) begin
      waitHb(gap);
      beats++;
    end
    checkCounts(3);

    // restart the time base right after a heartbeat
    writeReg(3'd3, 16'd1);
    waitHb(gap);
    if (gap - RESET_LATENCY > HB_GAP + 2 || gap - RESET_LATENCY < HB_GAP - 2) begin
      reportMismatch("heartbeat gap after time reset", gap - RESET_LATENCY, HB_GAP);
    end

    n = 0;
    while (hostCreds != `HOST_CREDITS && n < WAIT_LIMIT) begin
      @(posedge clk);
      #2;
      n++;
    end
    if (hostCreds != `HOST_CREDITS) begin
      reportMismatch("host credits after idle", hostCreds, `HOST_CREDITS);
    end

    $display("errors: %0d value, %0d other", valueErrors, otherErrors);
    if (valueErrors == 0 && otherErrors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+design
design/ConfPkg.sv
design/SpikePkg.sv
design/ConfBus.sv
design/HostConfPort.sv
design/ConfMapper.sv
design/Deserializer.sv
design/ProgMemArbiter.sv
design/SpikeGen.sv
design/TimeMgr.sv
design/SpikeCore.sv
testbench/SpikeCoreTb.sv

// ==== Makefile ====
# Verilator build and run of the SpikeCore testbench

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module SpikeCoreTb -f all.f -Mdir obj_dir
	@out="$$(./obj_dir/VSpikeCoreTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TB PASSED"

clean:
	rm -rf obj_dir
